// ==== include/rmt_params.svh ====
`ifndef RMT_PARAMS_SVH
`define RMT_PARAMS_SVH

// stream and pipeline sizing
`define RMT_DATA_W          32
`define RMT_NUM_STAGES      3
`define RMT_TABLE_DEPTH     16

// buffering
`define RMT_PKT_FIFO_DEPTH  32
`define RMT_PHV_FIFO_DEPTH  8
`define RMT_NEARLY_FULL_GAP 4

// header beat layout
`define RMT_KIND_MSB        31
`define RMT_KIND_LSB        28
`define RMT_VLAN_MSB        27
`define RMT_VLAN_LSB        16
`define RMT_FIELD_MSB       15
`define RMT_FIELD_LSB       0

// control packet layout
`define RMT_CTRL_STAGE_MSB  25
`define RMT_CTRL_STAGE_LSB  24
`define RMT_CTRL_IDX_MSB    19
`define RMT_CTRL_IDX_LSB    16
`define RMT_CTRL_OP_MSB     17
`define RMT_CTRL_OP_LSB     16

`endif

// ==== src/rmt_pkg.sv ====
`include "rmt_params.svh"

package rmt_pkg;

	// which path a packet takes
	typedef enum logic [3:0] {
		kind_data = 4'h0,
		kind_ctrl = 4'h1
	} pkt_kind_e;

	typedef enum logic [1:0] {
		op_nop = 2'd0,
		op_set = 2'd1,
		op_add = 2'd2,
		op_xor = 2'd3
	} act_op_e;

	typedef struct packed {
		logic [`RMT_VLAN_MSB-`RMT_VLAN_LSB:0]   vlan;
		logic [`RMT_FIELD_MSB-`RMT_FIELD_LSB:0] field;
	} phv_t;

	// one action table write, carried down the stage chain
	typedef struct packed {
		logic                                             valid;
		logic [`RMT_CTRL_STAGE_MSB-`RMT_CTRL_STAGE_LSB:0] stage;
		logic [`RMT_CTRL_IDX_MSB-`RMT_CTRL_IDX_LSB:0]     idx;
		act_op_e                                          op;
		logic [`RMT_FIELD_MSB-`RMT_FIELD_LSB:0]           operand;
	} tbl_wr_t;

endpackage

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             aresetn,
	input  logic [WIDTH-1:0] din,
	input  logic             wr_en,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             nearly_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr       = wr_en && (count != CNT_W'(DEPTH));
	assign do_rd       = rd_en && !empty;
	assign empty       = (count == '0);
	assign nearly_full = (count >= CNT_W'(DEPTH - `RMT_NEARLY_FULL_GAP));

	// fall-through read port
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== src/match_stage.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module match_stage #(
	parameter int unsigned STAGE_ID = 0
) (
	input  logic             clk,
	input  logic             aresetn,
	input  rmt_pkg::phv_t    phv_in,
	input  logic             phv_in_valid,
	input  rmt_pkg::tbl_wr_t tbl_wr_in,
	output rmt_pkg::phv_t    phv_out,
	output logic             phv_out_valid,
	output rmt_pkg::tbl_wr_t tbl_wr_out
);

	localparam int IDX_W = $clog2(`RMT_TABLE_DEPTH);
	localparam int SID_W = `RMT_CTRL_STAGE_MSB - `RMT_CTRL_STAGE_LSB + 1;

	rmt_pkg::act_op_e                       op_tbl      [`RMT_TABLE_DEPTH];
	logic [`RMT_FIELD_MSB-`RMT_FIELD_LSB:0] operand_tbl [`RMT_TABLE_DEPTH];

	logic                                   tbl_hit;
	logic [IDX_W-1:0]                       lookup_idx;
	rmt_pkg::act_op_e                       act_op;
	logic [`RMT_FIELD_MSB-`RMT_FIELD_LSB:0] act_operand;
	logic [`RMT_FIELD_MSB-`RMT_FIELD_LSB:0] field_next;

	assign tbl_hit     = tbl_wr_in.valid && (tbl_wr_in.stage == STAGE_ID[SID_W-1:0]);
	assign lookup_idx  = phv_in.vlan[IDX_W-1:0];
	assign act_op      = op_tbl[lookup_idx];
	assign act_operand = operand_tbl[lookup_idx];

	// arithmetic wraps at the field width
	always_comb begin
		case (act_op)
			rmt_pkg::op_set: field_next = act_operand;
			rmt_pkg::op_add: field_next = phv_in.field + act_operand;
			rmt_pkg::op_xor: field_next = phv_in.field ^ act_operand;
			default:         field_next = phv_in.field;
		endcase
	end

	// opcodes come up as nop
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < `RMT_TABLE_DEPTH; i++)
				op_tbl[i] <= rmt_pkg::op_nop;
		end else if (tbl_hit) begin
			op_tbl[tbl_wr_in.idx] <= tbl_wr_in.op;
		end
	end

	always_ff @(posedge clk) begin
		if (tbl_hit)
			operand_tbl[tbl_wr_in.idx] <= tbl_wr_in.operand;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_out_valid    <= 1'b0;
			tbl_wr_out.valid <= 1'b0;
		end else begin
			phv_out_valid <= phv_in_valid;
			tbl_wr_out    <= tbl_wr_in;
		end
	end

	always_ff @(posedge clk) begin
		phv_out.vlan  <= phv_in.vlan;
		phv_out.field <= field_next;
	end

endmodule

// ==== src/ingress_parser.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module ingress_parser (
	input  logic                   clk,
	input  logic                   aresetn,
	input  logic [31:0]            vlan_drop_flags,
	input  logic [`RMT_DATA_W-1:0] in_data,
	input  logic                   in_valid,
	input  logic                   in_last,
	output logic                   in_ready,
	input  logic                   fifo_almost_full,
	output logic [31:0]            ctrl_token,
	output rmt_pkg::phv_t          phv,
	output logic                   phv_valid,
	output rmt_pkg::tbl_wr_t       tbl_wr,
	output logic [`RMT_DATA_W:0]   pkt_data,
	output logic                   pkt_wr
);

	typedef enum logic [1:0] {
		st_idle,
		st_data,
		st_drop,
		st_ctrl
	} state_e;

	state_e             state;
	logic               accept;
	logic               is_hdr;
	rmt_pkg::pkt_kind_e hdr_kind;
	logic               hdr_keep;
	logic               ctrl_beat;
	logic               ctrl_beat1;
	rmt_pkg::tbl_wr_t   ctrl_acc;
	rmt_pkg::tbl_wr_t   next_wr;

	assign in_ready = ~fifo_almost_full;
	assign accept   = in_valid & in_ready;
	assign is_hdr   = (state == st_idle);
	assign hdr_kind = rmt_pkg::pkt_kind_e'(in_data[`RMT_KIND_MSB:`RMT_KIND_LSB]);

	// low five vlan bits pick a drop flag; unknown kinds are dropped as well
	assign hdr_keep = (hdr_kind == rmt_pkg::kind_data) &&
			!vlan_drop_flags[in_data[`RMT_VLAN_LSB+4:`RMT_VLAN_LSB]];

	assign ctrl_beat = (is_hdr && hdr_kind == rmt_pkg::kind_ctrl) || (state == st_ctrl);

	assign pkt_data = {in_last, in_data};
	assign pkt_wr   = accept && ((is_hdr && hdr_keep) || state == st_data);

	// table write as it stands after the current control beat
	always_comb begin
		next_wr = ctrl_acc;
		if (is_hdr) begin
			next_wr.stage   = in_data[`RMT_CTRL_STAGE_MSB:`RMT_CTRL_STAGE_LSB];
			next_wr.idx     = in_data[`RMT_CTRL_IDX_MSB:`RMT_CTRL_IDX_LSB];
			next_wr.op      = rmt_pkg::op_nop;
			next_wr.operand = '0;
		end else if (ctrl_beat1) begin
			next_wr.op      = rmt_pkg::act_op_e'(in_data[`RMT_CTRL_OP_MSB:`RMT_CTRL_OP_LSB]);
			next_wr.operand = in_data[`RMT_FIELD_MSB:`RMT_FIELD_LSB];
		end
		next_wr.valid = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state        <= st_idle;
			phv_valid    <= 1'b0;
			tbl_wr.valid <= 1'b0;
			ctrl_beat1   <= 1'b0;
			ctrl_token   <= '0;
		end else begin
			phv_valid    <= 1'b0;
			tbl_wr.valid <= 1'b0;
			if (accept) begin
				case (state)
					st_idle: begin
						if (!in_last) begin
							if (hdr_kind == rmt_pkg::kind_ctrl)
								state <= st_ctrl;
							else if (hdr_keep)
								state <= st_data;
							else
								state <= st_drop;
						end
						if (hdr_keep)
							phv_valid <= 1'b1;
					end
					default: begin
						if (in_last)
							state <= st_idle;
					end
				endcase

				if (ctrl_beat) begin
					ctrl_beat1 <= is_hdr;
					if (in_last) begin
						tbl_wr     <= next_wr;
						ctrl_token <= ctrl_token + 32'd1;
					end
				end
			end
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (accept && is_hdr) begin
			phv.vlan  <= in_data[`RMT_VLAN_MSB:`RMT_VLAN_LSB];
			phv.field <= in_data[`RMT_FIELD_MSB:`RMT_FIELD_LSB];
		end
		if (accept && ctrl_beat)
			ctrl_acc <= next_wr;
	end

endmodule

// ==== src/deparser.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module deparser (
	input  logic                   clk,
	input  logic                   aresetn,
	input  logic [`RMT_DATA_W:0]   pkt_dout,
	input  logic                   pkt_empty,
	output logic                   pkt_rd,
	input  rmt_pkg::phv_t          phv_dout,
	input  logic                   phv_empty,
	output logic                   phv_rd,
	output logic [`RMT_DATA_W-1:0] out_data,
	output logic                   out_valid,
	output logic                   out_last,
	input  logic                   out_ready
);

	logic                   first_beat;
	logic [`RMT_DATA_W-1:0] pkt_beat;
	logic                   pkt_last;
	logic [`RMT_DATA_W-1:0] hdr_beat;

	assign pkt_beat = pkt_dout[`RMT_DATA_W-1:0];
	assign pkt_last = pkt_dout[`RMT_DATA_W];

	// header beat with the processed field spliced in
	always_comb begin
		hdr_beat = pkt_beat;
		hdr_beat[`RMT_FIELD_MSB:`RMT_FIELD_LSB] = phv_dout.field;
	end

	// a header beat also waits for its phv
	assign out_valid = !pkt_empty && (!first_beat || !phv_empty);
	assign out_data  = first_beat ? hdr_beat : pkt_beat;
	assign out_last  = pkt_last;

	assign pkt_rd = out_valid && out_ready;
	assign phv_rd = pkt_rd && first_beat;

	always_ff @(posedge clk) begin
		if (!aresetn)
			first_beat <= 1'b1;
		else if (pkt_rd)
			first_beat <= pkt_last;
	end

endmodule

// ==== src/rmt_top.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module rmt_top (
	input  logic                   clk,
	input  logic                   aresetn,
	input  logic [31:0]            vlan_drop_flags,
	output logic [31:0]            ctrl_token,
	input  logic [`RMT_DATA_W-1:0] in_data,
	input  logic                   in_valid,
	input  logic                   in_last,
	output logic                   in_ready,
	output logic [`RMT_DATA_W-1:0] out_data,
	output logic                   out_valid,
	output logic                   out_last,
	input  logic                   out_ready
);

	localparam int PHV_W = $bits(rmt_pkg::phv_t);

	// index 0 is the parser output, index n the output of stage n-1
	rmt_pkg::phv_t    stg_phv       [`RMT_NUM_STAGES+1];
	logic             stg_phv_valid [`RMT_NUM_STAGES+1];
	rmt_pkg::tbl_wr_t stg_tbl_wr    [`RMT_NUM_STAGES+1];

	logic [`RMT_DATA_W:0] pkt_din;
	logic [`RMT_DATA_W:0] pkt_dout;
	logic                 pkt_wr;
	logic                 pkt_rd;
	logic                 pkt_empty;
	logic                 pkt_nearly_full;

	logic [PHV_W-1:0] phv_dout;
	logic             phv_rd;
	logic             phv_empty;
	logic             phv_nearly_full;

	ingress_parser u_parser (
		.clk              (clk),
		.aresetn          (aresetn),
		.vlan_drop_flags  (vlan_drop_flags),
		.in_data          (in_data),
		.in_valid         (in_valid),
		.in_last          (in_last),
		.in_ready         (in_ready),
		.fifo_almost_full (pkt_nearly_full | phv_nearly_full),
		.ctrl_token       (ctrl_token),
		.phv              (stg_phv[0]),
		.phv_valid        (stg_phv_valid[0]),
		.tbl_wr           (stg_tbl_wr[0]),
		.pkt_data         (pkt_din),
		.pkt_wr           (pkt_wr)
	);

	for (genvar i = 0; i < `RMT_NUM_STAGES; i++) begin : g_stage
		match_stage #(
			.STAGE_ID (i)
		) u_stage (
			.clk           (clk),
			.aresetn       (aresetn),
			.phv_in        (stg_phv[i]),
			.phv_in_valid  (stg_phv_valid[i]),
			.tbl_wr_in     (stg_tbl_wr[i]),
			.phv_out       (stg_phv[i+1]),
			.phv_out_valid (stg_phv_valid[i+1]),
			.tbl_wr_out    (stg_tbl_wr[i+1])
		);
	end

	sync_fifo #(
		.WIDTH (`RMT_DATA_W+1),
		.DEPTH (`RMT_PKT_FIFO_DEPTH)
	) u_pkt_fifo (
		.clk         (clk),
		.aresetn     (aresetn),
		.din         (pkt_din),
		.wr_en       (pkt_wr),
		.rd_en       (pkt_rd),
		.dout        (pkt_dout),
		.empty       (pkt_empty),
		.nearly_full (pkt_nearly_full)
	);

	sync_fifo #(
		.WIDTH (PHV_W),
		.DEPTH (`RMT_PHV_FIFO_DEPTH)
	) u_phv_fifo (
		.clk         (clk),
		.aresetn     (aresetn),
		.din         (stg_phv[`RMT_NUM_STAGES]),
		.wr_en       (stg_phv_valid[`RMT_NUM_STAGES]),
		.rd_en       (phv_rd),
		.dout        (phv_dout),
		.empty       (phv_empty),
		.nearly_full (phv_nearly_full)
	);

	deparser u_deparser (
		.clk       (clk),
		.aresetn   (aresetn),
		.pkt_dout  (pkt_dout),
		.pkt_empty (pkt_empty),
		.pkt_rd    (pkt_rd),
		.phv_dout  (phv_dout),
		.phv_empty (phv_empty),
		.phv_rd    (phv_rd),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_ready (out_ready)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic aresetn
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held for four rising edges, released on a falling edge
	initial begin
		aresetn = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
	end

endmodule

// ==== test/tb_monitor.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module tb_monitor (
	input logic                   clk,
	input logic                   aresetn,
	input logic [`RMT_DATA_W-1:0] out_data,
	input logic                   out_valid,
	input logic                   out_last,
	input logic                   out_ready,
	input logic [31:0]            ctrl_token
);

	// each entry holds {last, data}
	logic [`RMT_DATA_W:0] exp_q [$];
	logic [`RMT_DATA_W:0] exp_beat;

	int error_count   = 0;
	int test_errors   = 0;
	int tests_run     = 0;
	int tests_failed  = 0;
	int beats_checked = 0;

	function automatic int pending_beats();
		return exp_q.size();
	endfunction

	function automatic void expect_beat(input logic last, input logic [`RMT_DATA_W-1:0] data);
		exp_q.push_back({last, data});
	endfunction

	function automatic void count_error();
		error_count++;
		test_errors++;
	endfunction

	task automatic check_token(input logic [31:0] expected);
		if (ctrl_token !== expected) begin
			$display("mismatch at %0t: ctrl_token got %0d expected %0d",
				$time, ctrl_token, expected);
			count_error();
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic report_counts();
		$display("tests run %0d, tests failed %0d, beats checked %0d, errors %0d",
			tests_run, tests_failed, beats_checked, error_count);
	endtask

	// one beat per handshake, compared in order
	always @(posedge clk) begin
		if (aresetn && out_valid === 1'b1 && out_ready === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("unexpected output beat %h at %0t while nothing was expected",
					out_data, $time);
				count_error();
			end else begin
				exp_beat = exp_q.pop_front();
				beats_checked++;
				if (out_data !== exp_beat[`RMT_DATA_W-1:0]) begin
					$display("mismatch at %0t: out_data got %h expected %h",
						$time, out_data, exp_beat[`RMT_DATA_W-1:0]);
					count_error();
				end
				if (out_last !== exp_beat[`RMT_DATA_W]) begin
					$display("mismatch at %0t: out_last got %b expected %b",
						$time, out_last, exp_beat[`RMT_DATA_W]);
					count_error();
				end
			end
		end
	end

endmodule

// ==== test/rmt_checker.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module rmt_checker (
	input logic                   clk,
	input logic                   aresetn,
	input logic [`RMT_DATA_W-1:0] out_data,
	input logic                   out_valid,
	input logic                   out_last,
	input logic                   out_ready
);

	int assert_failures = 0;

	// a stalled beat holds until taken
	a_hold_stalled: assert property (@(posedge clk) disable iff (!aresetn)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
	else begin
		assert_failures++;
		$error("output beat changed while stalled");
	end

	// state after a reset edge has no valid output
	a_reset_quiet: assert property (@(posedge clk) !aresetn |=> !out_valid)
	else begin
		assert_failures++;
		$error("out_valid high during reset");
	end

	a_valid_known: assert property (@(posedge clk) disable iff (!aresetn)
		!$isunknown(out_valid))
	else begin
		assert_failures++;
		$error("out_valid is unknown");
	end

endmodule

bind rmt_top rmt_checker u_checker (
	.clk       (clk),
	.aresetn   (aresetn),
	.out_data  (out_data),
	.out_valid (out_valid),
	.out_last  (out_last),
	.out_ready (out_ready)
);

// ==== test/tb_top.sv ====
`timescale 1ns/1ps
`include "rmt_params.svh"

module tb_top;

	localparam string TRACE_FILE = "test/rmt_trace.txt";

	logic                   clk;
	logic                   aresetn;
	logic [31:0]            vlan_drop_flags;
	logic [31:0]            ctrl_token;
	logic [`RMT_DATA_W-1:0] in_data;
	logic                   in_valid;
	logic                   in_last;
	logic                   in_ready;
	logic [`RMT_DATA_W-1:0] out_data;
	logic                   out_valid;
	logic                   out_last;
	logic                   out_ready;

	string trace_lines [$];
	int    ready_pct   = 100;
	int    total_beats = 0;
	int    cycle_limit = 1000000;
	int    cycle_count = 0;
	int    bad_records = 0;
	bit    trace_ok;

	tb_clock u_clock (
		.clk     (clk),
		.aresetn (aresetn)
	);

	rmt_top DUT (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.ctrl_token      (ctrl_token),
		.in_data         (in_data),
		.in_valid        (in_valid),
		.in_last         (in_last),
		.in_ready        (in_ready),
		.out_data        (out_data),
		.out_valid       (out_valid),
		.out_last        (out_last),
		.out_ready       (out_ready)
	);

	tb_monitor u_mon (
		.clk        (clk),
		.aresetn    (aresetn),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.out_last   (out_last),
		.out_ready  (out_ready),
		.ctrl_token (ctrl_token)
	);

	// sink ready pattern from the trace percentage
	initial begin
		void'($urandom(32'hb3625ea3));
		forever begin
			@(negedge clk);
			out_ready = ($urandom % 100) < ready_pct;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles with %0d expected beats still outstanding",
				cycle_count, u_mon.pending_beats());
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic load_trace(output bit ok);
		int    fd;
		string line;
		fd = $fopen(TRACE_FILE, "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line.getc(0) != "#")
					trace_lines.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	// starts on a falling edge and returns on the one after the transfer
	task automatic send_beat(input logic last, input logic [`RMT_DATA_W-1:0] data);
		logic took;
		in_valid = 1'b1;
		in_data  = data;
		in_last  = last;
		took     = 1'b0;
		while (!took) begin
			took = in_ready;
			@(negedge clk);
		end
		in_valid = 1'b0;
	endtask

	task automatic run_trace();
		byte         tag;
		string       rest;
		string       test_name;
		int          last;
		logic [31:0] val;
		logic [31:0] exp_token;
		bit          has_token;
		test_name = "unnamed";
		has_token = 1'b0;
		foreach (trace_lines[i]) begin
			tag  = trace_lines[i].getc(0);
			rest = trace_lines[i].substr(1, trace_lines[i].len() - 1);
			case (tag)
				"N": void'($sscanf(rest, "%s", test_name));
				"F": begin
					void'($sscanf(rest, "%h", val));
					vlan_drop_flags = val;
				end
				"R": void'($sscanf(rest, "%d", ready_pct));
				"I": begin
					void'($sscanf(rest, "%d %h", last, val));
					send_beat(last != 0, val);
				end
				"E": begin
					void'($sscanf(rest, "%d %h", last, val));
					u_mon.expect_beat(last != 0, val);
				end
				"P": begin
					void'($sscanf(rest, "%d %h", last, val));
					u_mon.expect_beat(last != 0, val);
					send_beat(last != 0, val);
				end
				"T": begin
					void'($sscanf(rest, "%d", exp_token));
					has_token = 1'b1;
				end
				"X": begin
					while (u_mon.pending_beats() > 0)
						@(negedge clk);
					// quiet period so that stray beats show up
					repeat (12) @(negedge clk);
					if (has_token)
						u_mon.check_token(exp_token);
					has_token = 1'b0;
					u_mon.end_test(test_name);
				end
				default: begin
					$display("trace record not understood: %s", trace_lines[i]);
					bad_records++;
				end
			endcase
		end
	endtask

	initial begin
		in_valid        = 1'b0;
		in_data         = '0;
		in_last         = 1'b0;
		vlan_drop_flags = '0;
		out_ready       = 1'b0;
		load_trace(trace_ok);
		foreach (trace_lines[i]) begin
			if (trace_lines[i].getc(0) == "I" || trace_lines[i].getc(0) == "P")
				total_beats++;
		end
		cycle_limit = 20 * total_beats + 100;
		if (trace_ok) begin
			wait (aresetn === 1'b1);
			@(negedge clk);
			run_trace();
			u_mon.report_counts();
		end
		if (!trace_ok) begin
			$display("could not open the trace file %s", TRACE_FILE);
			$display("Result: FAILED");
		end else if (u_mon.error_count + bad_records + DUT.u_checker.assert_failures == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== test/rmt_trace.txt ====
# N name | F drop flags hex | R out_ready percent | T expected ctrl_token | X end of test
# I last data = input beat, E last data = expected output beat, P = both, passed unchanged
N passthru
F 00000000
R 60
P 0 00051234
P 0 deadbeef
P 1 01020304
P 1 00070042
X
N drop
F 00000020
I 0 00259999
I 0 11111111
I 1 22222222
P 0 0006abcd
P 1 33333333
X
N stage1_add
F 00000000
I 0 11030000
I 1 00020100
E 0 00130080
I 0 0013ff80
P 1 cafef00d
T 1
X
N stage_order
I 0 10090000
I 1 00011200
I 0 11090000
I 1 00020034
I 0 12090000
I 0 000300ff
I 1 77777777
E 0 000912cb
I 0 00095555
P 1 0badc0de
P 1 000a5555
T 4
X
N burst
R 5
P 0 00205000
P 0 a0000001
P 0 a0000002
P 0 a0000003
P 0 a0000004
P 0 a0000005
P 0 a0000006
P 0 a0000007
P 0 a0000008
P 1 a0000009
P 0 00216000
P 0 b0000001
P 0 b0000002
P 0 b0000003
P 0 b0000004
P 0 b0000005
P 0 b0000006
P 0 b0000007
P 0 b0000008
P 1 b0000009
E 0 01030101
I 0 01030001
P 0 c0000001
P 0 c0000002
P 0 c0000003
P 0 c0000004
P 0 c0000005
P 0 c0000006
P 0 c0000007
P 0 c0000008
P 1 c0000009
R 40
P 1 00407000
P 1 00417001
P 1 00427002
P 1 00447004
P 1 00457005
T 4
X

// ==== build.f ====
+incdir+include
src/rmt_pkg.sv
src/sync_fifo.sv
src/match_stage.sv
src/ingress_parser.sv
src/deparser.sv
src/rmt_top.sv
test/tb_clock.sv
test/tb_monitor.sv
test/rmt_checker.sv
test/tb_top.sv

// ==== Bender.yml ====
package:
  name: rmt_pipeline

sources:
  - include_dirs:
      - include
    files:
      - src/rmt_pkg.sv
      - src/sync_fifo.sv
      - src/match_stage.sv
      - src/ingress_parser.sv
      - src/deparser.sv
      - src/rmt_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clock.sv
      - test/tb_monitor.sv
      - test/rmt_checker.sv
      - test/tb_top.sv
